//--- common/mem_params.svh
/*
 * widths, SRAM depth, timer address and requester tags
 * SRAM depth must be a power of two, addresses wrap modulo the depth
 * timer occupies exactly two words at MEM_RTC_ADDR and MEM_RTC_ADDR+4
 */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

`define MEM_ADDR_W 32
`define MEM_DATA_W 32
`define MEM_STRB_W (`MEM_DATA_W / 8)
`define MEM_ID_W 4

// word count of the SRAM
`define MEM_SRAM_WORDS 256

// low word of the real-time counter, high word follows at +4
`define MEM_RTC_ADDR 32'ha000_0048

// tags carried on ar_id / aw_id
`define MEM_ID_FETCH 4'h1
`define MEM_ID_DATA 4'h2

`endif

//--- common/mem_pkg.sv
/*
 * shared types of the memory subsystem
 * response codes follow AXI, only single-beat sizes up to one word
 */
`default_nettype none

package mem_pkg;

	// AXI response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_t;

	// bytes per beat as log2, nothing wider than the data bus
	typedef enum logic [2:0] {
		SIZE_1B = 3'd0,
		SIZE_2B = 3'd1,
		SIZE_4B = 3'd2
	} size_t;

	// target of the granted transaction
	typedef enum logic {
		DEV_SRAM = 1'b0,
		DEV_RTC  = 1'b1
	} device_t;

	// arbiter FSM
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		BUSY_DATA = 2'd1, // load/store port owns the bus
		BUSY_INST = 2'd2  // fetch port owns the bus
	} arb_state_t;

endpackage

`default_nettype wire

//--- common/axi_lite_if.sv
/*
 * single-beat AXI channel set, no bursts, no last
 * ids only tag the requester, they never route responses
 */
`default_nettype none
`include "mem_params.svh"

interface axi_lite_if import mem_pkg::*; ();

	// read address
	logic [`MEM_ADDR_W-1:0] ar_addr;
	logic [`MEM_ID_W-1:0]   ar_id;
	size_t                  ar_size;
	logic                   ar_valid;
	logic                   ar_ready;

	// read data
	logic [`MEM_DATA_W-1:0] r_data;
	resp_t                  r_resp;
	logic                   r_valid;
	logic                   r_ready;

	// write address
	logic [`MEM_ADDR_W-1:0] aw_addr;
	logic [`MEM_ID_W-1:0]   aw_id;
	size_t                  aw_size;
	logic                   aw_valid;
	logic                   aw_ready;

	// write data
	logic [`MEM_DATA_W-1:0] w_data;
	logic [`MEM_STRB_W-1:0] w_strb;
	logic                   w_valid;
	logic                   w_ready;

	// write response
	resp_t                  b_resp;
	logic                   b_valid;
	logic                   b_ready;

	modport manager (
		output ar_addr, ar_id, ar_size, ar_valid, input ar_ready,
		input r_data, r_resp, r_valid, output r_ready,
		output aw_addr, aw_id, aw_size, aw_valid, input aw_ready,
		output w_data, w_strb, w_valid, input w_ready,
		input b_resp, b_valid, output b_ready
	);

	modport subordinate (
		input ar_addr, ar_id, ar_size, ar_valid, output ar_ready,
		output r_data, r_resp, r_valid, input r_ready,
		input aw_addr, aw_id, aw_size, aw_valid, output aw_ready,
		input w_data, w_strb, w_valid, output w_ready,
		output b_resp, b_valid, input b_ready
	);

endinterface

`default_nettype wire

//--- hw/axi_arbiter/axi_arbiter.sv
/*
 * one transaction in flight, priority write > data read > fetch
 * write is granted only when aw and w are presented together
 * device select is decoded at grant and held until the response handshake
 */
`default_nettype none
`include "mem_params.svh"

module axi_arbiter import mem_pkg::*; (
	input  wire                    clock,
	input  wire                    reset,

	// fetch read
	input  wire [`MEM_ADDR_W-1:0]  fetch_ar_addr_i,
	input  wire                    fetch_ar_valid_i,
	output logic                   fetch_ar_ready_o,
	output logic [`MEM_DATA_W-1:0] fetch_r_data_o,
	output resp_t                  fetch_r_resp_o,
	output logic                   fetch_r_valid_o,
	input  wire                    fetch_r_ready_i,

	// data read
	input  wire [`MEM_ADDR_W-1:0]  data_ar_addr_i,
	input  size_t                  data_ar_size_i,
	input  wire                    data_ar_valid_i,
	output logic                   data_ar_ready_o,
	output logic [`MEM_DATA_W-1:0] data_r_data_o,
	output resp_t                  data_r_resp_o,
	output logic                   data_r_valid_o,
	input  wire                    data_r_ready_i,

	// data write
	input  wire [`MEM_ADDR_W-1:0]  data_aw_addr_i,
	input  size_t                  data_aw_size_i,
	input  wire                    data_aw_valid_i,
	output logic                   data_aw_ready_o,
	input  wire [`MEM_DATA_W-1:0]  data_w_data_i,
	input  wire [`MEM_STRB_W-1:0]  data_w_strb_i,
	input  wire                    data_w_valid_i,
	output logic                   data_w_ready_o,
	output resp_t                  data_b_resp_o,
	output logic                   data_b_valid_o,
	input  wire                    data_b_ready_i,

	axi_lite_if.manager            bus_m,
	output device_t                device_o
);

	arb_state_t             state, state_next;
	device_t                device_q;
	logic                   idle, busy_data, busy_inst;
	logic                   sel_write, sel_data_rd, sel_fetch;
	logic                   wr_grant, rd_grant;
	logic [`MEM_ADDR_W-1:0] grant_addr;

	function automatic device_t decode_dev(input logic [`MEM_ADDR_W-1:0] addr);
		if (addr == `MEM_RTC_ADDR || addr == `MEM_RTC_ADDR + 32'd4) begin
			return DEV_RTC;
		end
		return DEV_SRAM;
	endfunction

	assign idle      = (state == IDLE);
	assign busy_data = (state == BUSY_DATA);
	assign busy_inst = (state == BUSY_INST);

	// winner picked from valids alone, ready only confirms the grant
	assign sel_write   = data_aw_valid_i & data_w_valid_i;
	assign sel_data_rd = ~sel_write & data_ar_valid_i;
	assign sel_fetch   = ~sel_write & ~data_ar_valid_i & fetch_ar_valid_i;

	assign grant_addr = sel_write ? data_aw_addr_i :
		sel_data_rd ? data_ar_addr_i : fetch_ar_addr_i;
	assign device_o = idle ? decode_dev(grant_addr) : device_q;

	// request side of the manager bus
	assign bus_m.ar_valid = idle & (sel_data_rd | sel_fetch);
	assign bus_m.ar_addr  = sel_data_rd ? data_ar_addr_i : fetch_ar_addr_i;
	assign bus_m.ar_size  = sel_data_rd ? data_ar_size_i : SIZE_4B; // fetch is always a word
	assign bus_m.ar_id    = sel_data_rd ? `MEM_ID_DATA : `MEM_ID_FETCH;

	assign bus_m.aw_valid = idle & sel_write;
	assign bus_m.aw_addr  = data_aw_addr_i;
	assign bus_m.aw_size  = data_aw_size_i;
	assign bus_m.aw_id    = `MEM_ID_DATA;
	assign bus_m.w_valid  = idle & sel_write;
	assign bus_m.w_data   = data_w_data_i;
	assign bus_m.w_strb   = data_w_strb_i;

	assign wr_grant = bus_m.aw_valid & bus_m.aw_ready & bus_m.w_ready;
	assign rd_grant = bus_m.ar_valid & bus_m.ar_ready;

	// ready goes back to the winner only
	assign data_aw_ready_o  = wr_grant;
	assign data_w_ready_o   = wr_grant;
	assign data_ar_ready_o  = rd_grant & sel_data_rd;
	assign fetch_ar_ready_o = rd_grant & sel_fetch;

	// responses, valids steered by owner
	assign data_r_valid_o  = busy_data & bus_m.r_valid;
	assign data_b_valid_o  = busy_data & bus_m.b_valid;
	assign fetch_r_valid_o = busy_inst & bus_m.r_valid;
	assign data_r_data_o   = bus_m.r_data;
	assign data_r_resp_o   = bus_m.r_resp;
	assign fetch_r_data_o  = bus_m.r_data;
	assign fetch_r_resp_o  = bus_m.r_resp;
	assign data_b_resp_o   = bus_m.b_resp;

	assign bus_m.r_ready = (busy_data & data_r_ready_i) | (busy_inst & fetch_r_ready_i);
	assign bus_m.b_ready = busy_data & data_b_ready_i;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (wr_grant || (rd_grant && sel_data_rd)) begin
					state_next = BUSY_DATA;
				end else if (rd_grant && sel_fetch) begin
					state_next = BUSY_INST;
				end
			end
			BUSY_DATA: begin
				// either a read or a write is pending, never both
				if ((bus_m.r_valid && data_r_ready_i) || (bus_m.b_valid && data_b_ready_i)) begin
					state_next = IDLE;
				end
			end
			BUSY_INST: begin
				if (bus_m.r_valid && fetch_r_ready_i) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= IDLE;
			device_q <= DEV_SRAM;
		end else begin
			state <= state_next;
			if (idle) begin
				device_q <= device_o; // latched every idle cycle, frozen once busy
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/axi_xbar/axi_xbar.sv
/*
 * one manager to two subordinates, steered by the held device select
 * the unselected subordinate sees no valids and no readies
 */
`default_nettype none

module axi_xbar import mem_pkg::*; (
	input  device_t         device_i,
	axi_lite_if.subordinate bus_s,
	axi_lite_if.manager     sram_m,
	axi_lite_if.manager     rtc_m
);

	logic to_rtc;

	assign to_rtc = (device_i == DEV_RTC);

	// payload fans out to both, only valids are steered
	assign sram_m.ar_addr = bus_s.ar_addr;
	assign sram_m.ar_id   = bus_s.ar_id;
	assign sram_m.ar_size = bus_s.ar_size;
	assign sram_m.aw_addr = bus_s.aw_addr;
	assign sram_m.aw_id   = bus_s.aw_id;
	assign sram_m.aw_size = bus_s.aw_size;
	assign sram_m.w_data  = bus_s.w_data;
	assign sram_m.w_strb  = bus_s.w_strb;

	assign rtc_m.ar_addr = bus_s.ar_addr;
	assign rtc_m.ar_id   = bus_s.ar_id;
	assign rtc_m.ar_size = bus_s.ar_size;
	assign rtc_m.aw_addr = bus_s.aw_addr;
	assign rtc_m.aw_id   = bus_s.aw_id;
	assign rtc_m.aw_size = bus_s.aw_size;
	assign rtc_m.w_data  = bus_s.w_data;
	assign rtc_m.w_strb  = bus_s.w_strb;

	assign sram_m.ar_valid = bus_s.ar_valid & ~to_rtc;
	assign sram_m.aw_valid = bus_s.aw_valid & ~to_rtc;
	assign sram_m.w_valid  = bus_s.w_valid & ~to_rtc;
	assign sram_m.r_ready  = bus_s.r_ready & ~to_rtc;
	assign sram_m.b_ready  = bus_s.b_ready & ~to_rtc;

	assign rtc_m.ar_valid = bus_s.ar_valid & to_rtc;
	assign rtc_m.aw_valid = bus_s.aw_valid & to_rtc;
	assign rtc_m.w_valid  = bus_s.w_valid & to_rtc;
	assign rtc_m.r_ready  = bus_s.r_ready & to_rtc;
	assign rtc_m.b_ready  = bus_s.b_ready & to_rtc;

	// return path from the selected one
	assign bus_s.ar_ready = to_rtc ? rtc_m.ar_ready : sram_m.ar_ready;
	assign bus_s.aw_ready = to_rtc ? rtc_m.aw_ready : sram_m.aw_ready;
	assign bus_s.w_ready  = to_rtc ? rtc_m.w_ready : sram_m.w_ready;
	assign bus_s.r_data   = to_rtc ? rtc_m.r_data : sram_m.r_data;
	assign bus_s.r_resp   = to_rtc ? rtc_m.r_resp : sram_m.r_resp;
	assign bus_s.r_valid  = to_rtc ? rtc_m.r_valid : sram_m.r_valid;
	assign bus_s.b_resp   = to_rtc ? rtc_m.b_resp : sram_m.b_resp;
	assign bus_s.b_valid  = to_rtc ? rtc_m.b_valid : sram_m.b_valid;

endmodule

`default_nettype wire

//--- hw/axi_sram/axi_sram.sv
/*
 * word SRAM, index is the word address modulo the depth
 * expects aw and w together, one response pending at most, always OKAY
 */
`default_nettype none
`include "mem_params.svh"

module axi_sram import mem_pkg::*; (
	input wire              clock,
	input wire              reset,
	axi_lite_if.subordinate bus_s
);

	localparam int IDX_W = $clog2(`MEM_SRAM_WORDS);

	logic [`MEM_DATA_W-1:0] mem [`MEM_SRAM_WORDS];
	logic [`MEM_DATA_W-1:0] rd_data_q;
	logic                   r_valid_q, b_valid_q;
	logic                   free;
	logic                   rd_fire, wr_fire;
	logic [IDX_W-1:0]       rd_idx, wr_idx;

	// byte address in, upper bits drop off so accesses wrap
	assign rd_idx = bus_s.ar_addr[IDX_W+1:2];
	assign wr_idx = bus_s.aw_addr[IDX_W+1:2];

	assign free = ~r_valid_q & ~b_valid_q;

	assign bus_s.ar_ready = free;
	assign bus_s.aw_ready = free;
	assign bus_s.w_ready  = free;

	assign wr_fire = free & bus_s.aw_valid & bus_s.w_valid;
	assign rd_fire = free & bus_s.ar_valid & ~wr_fire;

	assign bus_s.r_data  = rd_data_q;
	assign bus_s.r_resp  = OKAY;
	assign bus_s.r_valid = r_valid_q;
	assign bus_s.b_resp  = OKAY;
	assign bus_s.b_valid = b_valid_q;

	// response flags, held until taken
	always_ff @(posedge clock) begin
		if (reset) begin
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (rd_fire) begin
				r_valid_q <= 1'b1;
			end else if (bus_s.r_ready) begin
				r_valid_q <= 1'b0;
			end
			if (wr_fire) begin
				b_valid_q <= 1'b1;
			end else if (bus_s.b_ready) begin
				b_valid_q <= 1'b0;
			end
		end
	end

	// storage and read data
	always_ff @(posedge clock) begin
		if (rd_fire) begin
			rd_data_q <= mem[rd_idx];
		end
		if (wr_fire) begin
			for (int i = 0; i < `MEM_STRB_W; i++) begin
				if (bus_s.w_strb[i]) begin
					mem[wr_idx][8*i +: 8] <= bus_s.w_data[8*i +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/rtc_timer/rtc_timer.sv
/*
 * 64-bit cycle counter read as two words, low word first
 * reading the low word latches the high word for a later high read
 * writes are refused with SLVERR and leave the counter alone
 */
`default_nettype none
`include "mem_params.svh"

module rtc_timer import mem_pkg::*; (
	input wire              clock,
	input wire              reset,
	axi_lite_if.subordinate bus_s
);

	logic [63:0]            count;
	logic [31:0]            hi_snap;
	logic [`MEM_DATA_W-1:0] rd_data_q;
	logic                   r_valid_q, b_valid_q;
	logic                   free, rd_fire, wr_fire;

	assign free    = ~r_valid_q & ~b_valid_q;
	assign wr_fire = free & bus_s.aw_valid & bus_s.w_valid;
	assign rd_fire = free & bus_s.ar_valid & ~wr_fire;

	assign bus_s.ar_ready = free;
	assign bus_s.aw_ready = free;
	assign bus_s.w_ready  = free;
	assign bus_s.r_data   = rd_data_q;
	assign bus_s.r_resp   = OKAY;
	assign bus_s.r_valid  = r_valid_q;
	assign bus_s.b_resp   = SLVERR; // counter is read-only
	assign bus_s.b_valid  = b_valid_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			count     <= '0;
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			count <= count + 64'd1;
			if (rd_fire) begin
				r_valid_q <= 1'b1;
			end else if (bus_s.r_ready) begin
				r_valid_q <= 1'b0;
			end
			if (wr_fire) begin
				b_valid_q <= 1'b1;
			end else if (bus_s.b_ready) begin
				b_valid_q <= 1'b0;
			end
		end
	end

	// bit 2 picks the word, the crossbar only routes the two timer addresses here
	always_ff @(posedge clock) begin
		if (rd_fire) begin
			if (bus_s.ar_addr[2]) begin
				rd_data_q <= hi_snap;
			end else begin
				rd_data_q <= count[31:0];
				hi_snap   <= count[63:32];
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/mem_subsystem_top.sv
/*
 * fetch and load/store ports sharing one AXI path to SRAM and timer
 * one transaction at a time, requesters hold valid until ready
 */
`default_nettype none
`include "mem_params.svh"

module mem_subsystem_top import mem_pkg::*; (
	input  wire                    clock,
	input  wire                    reset,

	input  wire [`MEM_ADDR_W-1:0]  fetch_ar_addr_i,
	input  wire                    fetch_ar_valid_i,
	output logic                   fetch_ar_ready_o,
	output logic [`MEM_DATA_W-1:0] fetch_r_data_o,
	output resp_t                  fetch_r_resp_o,
	output logic                   fetch_r_valid_o,
	input  wire                    fetch_r_ready_i,

	input  wire [`MEM_ADDR_W-1:0]  data_ar_addr_i,
	input  size_t                  data_ar_size_i,
	input  wire                    data_ar_valid_i,
	output logic                   data_ar_ready_o,
	output logic [`MEM_DATA_W-1:0] data_r_data_o,
	output resp_t                  data_r_resp_o,
	output logic                   data_r_valid_o,
	input  wire                    data_r_ready_i,

	input  wire [`MEM_ADDR_W-1:0]  data_aw_addr_i,
	input  size_t                  data_aw_size_i,
	input  wire                    data_aw_valid_i,
	output logic                   data_aw_ready_o,
	input  wire [`MEM_DATA_W-1:0]  data_w_data_i,
	input  wire [`MEM_STRB_W-1:0]  data_w_strb_i,
	input  wire                    data_w_valid_i,
	output logic                   data_w_ready_o,
	output resp_t                  data_b_resp_o,
	output logic                   data_b_valid_o,
	input  wire                    data_b_ready_i
);

	axi_lite_if bus ();      // arbiter to crossbar
	axi_lite_if sram_bus ();
	axi_lite_if rtc_bus ();

	device_t device;

	axi_arbiter i_axi_arbiter (
		.clock, .reset,
		.fetch_ar_addr_i, .fetch_ar_valid_i, .fetch_ar_ready_o,
		.fetch_r_data_o, .fetch_r_resp_o, .fetch_r_valid_o, .fetch_r_ready_i,
		.data_ar_addr_i, .data_ar_size_i, .data_ar_valid_i, .data_ar_ready_o,
		.data_r_data_o, .data_r_resp_o, .data_r_valid_o, .data_r_ready_i,
		.data_aw_addr_i, .data_aw_size_i, .data_aw_valid_i, .data_aw_ready_o,
		.data_w_data_i, .data_w_strb_i, .data_w_valid_i, .data_w_ready_o,
		.data_b_resp_o, .data_b_valid_o, .data_b_ready_i,
		.bus_m    (bus.manager),
		.device_o (device)
	);

	axi_xbar i_axi_xbar (
		.device_i (device),
		.bus_s    (bus.subordinate),
		.sram_m   (sram_bus.manager),
		.rtc_m    (rtc_bus.manager)
	);

	axi_sram i_axi_sram (
		.clock, .reset,
		.bus_s (sram_bus.subordinate)
	);

	rtc_timer i_rtc_timer (
		.clock, .reset,
		.bus_s (rtc_bus.subordinate)
	);

endmodule

`default_nettype wire

//--- test/mem_subsystem_tb.sv
/*
 * testbench for mem_subsystem_top with concurrent assertions at the top ports
 * SRAM test addresses stay below 32'h8000_0000 so only the timer words decode to the timer
 * requesters hold valid until ready, response readies idle high
 */
`default_nettype none
`include "mem_params.svh"

module mem_subsystem_tb import mem_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int N_PAIRS    = 8;
	localparam int RTC_GAP    = 20;
	localparam int N_TXN      = 4*N_PAIRS + 8; // sram traffic plus dual reads and timer
	localparam int IDX_W      = $clog2(`MEM_SRAM_WORDS);

	// signals watched by wait_high
	localparam int P_AW_READY    = 0;
	localparam int P_AR_READY    = 1;
	localparam int P_FETCH_READY = 2;
	localparam int P_R_VALID     = 3;
	localparam int P_FETCH_VALID = 4;
	localparam int P_B_VALID     = 5;

	logic                   clock, reset;
	logic [`MEM_ADDR_W-1:0] fetch_ar_addr_i, data_ar_addr_i, data_aw_addr_i;
	logic                   fetch_ar_valid_i, fetch_r_ready_i;
	logic                   data_ar_valid_i, data_r_ready_i;
	logic                   data_aw_valid_i, data_w_valid_i, data_b_ready_i;
	size_t                  data_ar_size_i, data_aw_size_i;
	logic [`MEM_DATA_W-1:0] data_w_data_i;
	logic [`MEM_STRB_W-1:0] data_w_strb_i;
	logic                   fetch_ar_ready_o, fetch_r_valid_o;
	logic                   data_ar_ready_o, data_r_valid_o;
	logic                   data_aw_ready_o, data_w_ready_o, data_b_valid_o;
	logic [`MEM_DATA_W-1:0] fetch_r_data_o, data_r_data_o;
	resp_t                  fetch_r_resp_o, data_r_resp_o, data_b_resp_o;

	logic [`MEM_DATA_W-1:0] ref_mem [`MEM_SRAM_WORDS]; // expected SRAM contents
	logic [`MEM_ADDR_W-1:0] addrs [N_PAIRS];
	int                     seed = 32'h00f4_5de1;
	string                  test_name;
	logic [31:0]            exp_data, exp_fetch, rtc_base, rtc_gap, last_rd;
	resp_t                  exp_b_resp;
	logic                   rtc_mode; // load/store read checks a lower bound only
	logic                   data_rd_open, fetch_open, wr_open;

	mem_subsystem_top i_mem_subsystem_top (.*);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD/2) clock = ~clock;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic logic [IDX_W-1:0] word_idx(input logic [31:0] addr);
		return addr[IDX_W+1:2];
	endfunction

	function automatic logic probe(input int sel);
		case (sel)
			P_AW_READY:    return data_aw_ready_o;
			P_AR_READY:    return data_ar_ready_o;
			P_FETCH_READY: return fetch_ar_ready_o;
			P_R_VALID:     return data_r_valid_o;
			P_FETCH_VALID: return fetch_r_valid_o;
			default:       return data_b_valid_o;
		endcase
	endfunction

	// called just after a falling edge and returns mid low phase once the signal is high
	task automatic wait_high(input int sel);
		#1;
		while (!probe(sel)) begin
			@(negedge clock);
			#1;
		end
	endtask

	task automatic data_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input resp_t resp);
		logic [IDX_W-1:0] idx;
		idx = word_idx(addr);
		@(negedge clock);
		exp_b_resp      = resp;
		data_aw_addr_i  = addr;
		data_w_data_i   = data;
		data_w_strb_i   = strb;
		data_aw_valid_i = 1'b1;
		data_w_valid_i  = 1'b1;
		wr_open         = 1'b1;
		wait_high(P_AW_READY);
		@(negedge clock);
		data_aw_valid_i = 1'b0;
		data_w_valid_i  = 1'b0;
		wait_high(P_B_VALID);
		@(negedge clock);
		wr_open = 1'b0;
		if (resp == OKAY) begin // refused timer writes leave memory alone
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					ref_mem[idx][8*b +: 8] = data[8*b +: 8];
				end
			end
		end
	endtask

	task automatic data_read(input logic [31:0] addr, input logic [31:0] expected,
			input logic is_rtc);
		@(negedge clock);
		exp_data        = expected;
		rtc_mode        = is_rtc;
		data_ar_addr_i  = addr;
		data_ar_valid_i = 1'b1;
		data_rd_open    = 1'b1;
		wait_high(P_AR_READY);
		@(negedge clock);
		data_ar_valid_i = 1'b0;
		wait_high(P_R_VALID);
		last_rd = data_r_data_o; // baseline for the next timer read
		@(negedge clock);
		data_rd_open = 1'b0;
	endtask

	task automatic fetch_read(input logic [31:0] addr);
		@(negedge clock);
		exp_fetch        = ref_mem[word_idx(addr)];
		fetch_ar_addr_i  = addr;
		fetch_ar_valid_i = 1'b1;
		fetch_open       = 1'b1;
		wait_high(P_FETCH_READY);
		@(negedge clock);
		fetch_ar_valid_i = 1'b0;
		wait_high(P_FETCH_VALID);
		@(negedge clock);
		fetch_open = 1'b0;
	endtask

	// both ports request together and the data response may stall
	task automatic dual_read(input logic [31:0] d_addr, input logic [31:0] f_addr,
			input int stall);
		@(negedge clock);
		exp_data         = ref_mem[word_idx(d_addr)];
		exp_fetch        = ref_mem[word_idx(f_addr)];
		rtc_mode         = 1'b0;
		data_ar_addr_i   = d_addr;
		fetch_ar_addr_i  = f_addr;
		data_ar_valid_i  = 1'b1;
		fetch_ar_valid_i = 1'b1;
		data_rd_open     = 1'b1;
		fetch_open       = 1'b1;
		data_r_ready_i   = (stall == 0);
		wait_high(P_AR_READY);
		@(negedge clock);
		data_ar_valid_i = 1'b0;
		wait_high(P_R_VALID);
		repeat (stall) @(negedge clock);
		data_r_ready_i = 1'b1;
		wait_high(P_R_VALID);
		@(negedge clock);
		data_rd_open = 1'b0;
		wait_high(P_FETCH_READY);
		@(negedge clock);
		fetch_ar_valid_i = 1'b0;
		wait_high(P_FETCH_VALID);
		@(negedge clock);
		fetch_open = 1'b0;
	endtask

	// timer reads only have to advance by the gap
	assert property (@(posedge clock) disable iff (reset)
		data_r_valid_o && data_r_ready_i |->
			(rtc_mode ? (data_r_data_o - rtc_base) >= rtc_gap : data_r_data_o == exp_data))
	else report_failure($sformatf("Mismatch in %s: expected %h, actual %h", test_name,
		rtc_mode ? rtc_base + rtc_gap : exp_data, $sampled(data_r_data_o)));

	assert property (@(posedge clock) disable iff (reset)
		data_r_valid_o && data_r_ready_i |-> data_r_resp_o == OKAY)
	else report_failure($sformatf("Mismatch in %s: expected resp %0d, actual %0d",
		test_name, OKAY, $sampled(data_r_resp_o)));

	assert property (@(posedge clock) disable iff (reset)
		fetch_r_valid_o && fetch_r_ready_i |-> fetch_r_data_o == exp_fetch)
	else report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
		test_name, exp_fetch, $sampled(fetch_r_data_o)));

	assert property (@(posedge clock) disable iff (reset)
		fetch_r_valid_o && fetch_r_ready_i |-> fetch_r_resp_o == OKAY)
	else report_failure($sformatf("Mismatch in %s: expected resp %0d, actual %0d",
		test_name, OKAY, $sampled(fetch_r_resp_o)));

	assert property (@(posedge clock) disable iff (reset)
		data_b_valid_o && data_b_ready_i |-> data_b_resp_o == exp_b_resp)
	else report_failure($sformatf("Mismatch in %s: expected resp %0d, actual %0d",
		test_name, exp_b_resp, $sampled(data_b_resp_o)));

	// address and data of a write go across in the same cycle
	assert property (@(posedge clock) disable iff (reset)
		data_aw_valid_i && data_w_valid_i |-> data_aw_ready_o == data_w_ready_o)
	else report_failure({"write address and write data accepted in different cycles in ",
		test_name});

	// each port only sees responses to its own requests
	assert property (@(posedge clock) disable iff (reset)
		(!data_r_valid_o || data_rd_open) && (!fetch_r_valid_o || fetch_open) &&
		(!data_b_valid_o || wr_open) &&
		$onehot0({fetch_r_valid_o, data_r_valid_o, data_b_valid_o}))
	else report_failure({"response delivered to a port with no request open in ", test_name});

	assert property (@(posedge clock) disable iff (reset)
		!(fetch_ar_ready_o && data_ar_valid_i))
	else report_failure({"fetch granted ahead of a waiting data read in ", test_name});

	assert property (@(posedge clock) disable iff (reset)
		(fetch_r_valid_o || data_r_valid_o || data_b_valid_o) |->
			!(fetch_ar_ready_o || data_ar_ready_o || data_aw_ready_o || data_w_ready_o))
	else report_failure({"new request granted while a response was pending in ", test_name});

	assert property (@(posedge clock) disable iff (reset)
		$past(data_r_valid_o && !data_r_ready_i) |->
			data_r_valid_o && data_r_data_o == $past(data_r_data_o))
	else report_failure({"stalled read response dropped or changed in ", test_name});

	assert property (@(posedge clock)
		$past(reset) && !reset |-> !(fetch_ar_ready_o || data_ar_ready_o || data_aw_ready_o ||
			data_w_ready_o || fetch_r_valid_o || data_r_valid_o || data_b_valid_o))
	else report_failure("ready or valid output high in the first cycle after reset");

	initial begin
		#(CLK_PERIOD * 40 * N_TXN);
		report_failure($sformatf("timeout after %0d cycles, tests did not finish", 40 * N_TXN));
	end

	initial begin
		reset            = 1'b1;
		fetch_ar_addr_i  = '0;
		fetch_ar_valid_i = 1'b0;
		fetch_r_ready_i  = 1'b1;
		data_ar_addr_i   = '0;
		data_ar_size_i   = SIZE_4B;
		data_ar_valid_i  = 1'b0;
		data_r_ready_i   = 1'b1;
		data_aw_addr_i   = '0;
		data_aw_size_i   = SIZE_4B;
		data_aw_valid_i  = 1'b0;
		data_w_data_i    = '0;
		data_w_strb_i    = '0;
		data_w_valid_i   = 1'b0;
		data_b_ready_i   = 1'b1;
		test_name        = "reset";
		exp_data         = '0;
		exp_fetch        = '0;
		exp_b_resp       = OKAY;
		rtc_mode         = 1'b0;
		rtc_base         = '0;
		rtc_gap          = '0;
		last_rd          = '0;
		data_rd_open     = 1'b0;
		fetch_open       = 1'b0;
		wr_open          = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		test_name = "write_read";
		for (int i = 0; i < N_PAIRS; i++) begin
			addrs[i] = $random(seed) & 32'h7fff_fffc; // full address range wraps in the SRAM
			data_write(addrs[i], $random(seed), 4'hf, OKAY);
			data_write(addrs[i], $random(seed), 4'($random(seed)), OKAY);
			data_read(addrs[i], ref_mem[word_idx(addrs[i])], 1'b0);
		end

		test_name = "fetch_read";
		for (int i = 0; i < N_PAIRS; i++) begin
			fetch_read(addrs[i] ^ 32'h0001_0000); // alias of the same word
		end

		test_name = "priority";
		dual_read(addrs[0], addrs[1], 0);
		test_name = "back_pressure";
		dual_read(addrs[2], addrs[3], 6);

		test_name = "timer_read";
		data_read(`MEM_RTC_ADDR, '0, 1'b1);
		rtc_base = last_rd;
		repeat (RTC_GAP) @(negedge clock);
		rtc_gap = 32'(RTC_GAP);
		data_read(`MEM_RTC_ADDR, '0, 1'b1);
		test_name = "timer_high";
		data_read(`MEM_RTC_ADDR + 32'd4, '0, 1'b0); // high word still zero this early
		test_name = "timer_write";
		data_write(`MEM_RTC_ADDR, $random(seed), 4'hf, SLVERR);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/mem_pkg.sv
common/axi_lite_if.sv
hw/axi_arbiter/axi_arbiter.sv
hw/axi_xbar/axi_xbar.sv
hw/axi_sram/axi_sram.sv
hw/rtc_timer/rtc_timer.sv
hw/mem_subsystem_top.sv
test/mem_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, a failing run returns non-zero
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f list.f --top-module mem_subsystem_tb -o mem_subsystem_sim

./obj_dir/mem_subsystem_sim
